//--- kd_params.svh
/*
 kd-tree search sizing
 depth, node count and patch geometry shared by package and rtl
*/

`ifndef KD_PARAMS_SVH
`define KD_PARAMS_SVH

// tree levels, also search latency in cycles
`define KD_DEPTH 6

// internal nodes, (1 << KD_DEPTH) - 1
`define KD_NODES 63

// components per patch
`define KD_COMPONENTS 5

// bits per component, per median and per index field
`define KD_COMP_WIDTH 11

`endif

//--- logic/kd_load_fsm.sv
/*
 tree load controller
 serial load sequencing, host write arbitration and search ready
*/

`timescale 1ns/1ps
`default_nettype none

module kd_load_fsm (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  load_start_i,   // pulse, restarts a serial load from any state
    input  wire  load_valid_i,   // serial word present
    input  wire  cfg_wr_i,       // host write strobe
    input  wire  cnt_last_i,     // counter at last node
    output logic cnt_clr_o,
    output logic cnt_adv_o,
    output logic tbl_wen_o,
    output logic tbl_sel_host_o, // 1 = host addr/data, 0 = serial load
    output logic ready_o
);

    kd_pkg::load_state_e state_q;
    kd_pkg::load_state_e state_d;
    logic                ready_q;
    logic                load_wr;   // serial word accepted this cycle
    logic                host_wr;   // host write accepted this cycle

    // a fresh start in LOAD discards the word offered alongside it
    assign load_wr = (state_q == kd_pkg::LOAD) && load_valid_i && !load_start_i;
    // host port locked out while the stream owns the table
    assign host_wr = (state_q != kd_pkg::LOAD) && cfg_wr_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            kd_pkg::IDLE: begin
                if (load_start_i) state_d = kd_pkg::LOAD;
            end
            kd_pkg::LOAD: begin
                if (load_start_i) begin
                    state_d = kd_pkg::LOAD; // restart, counter clears
                end else if (load_wr && cnt_last_i) begin
                    state_d = kd_pkg::READY; // node 62 written
                end
            end
            kd_pkg::READY: begin
                if (load_start_i) state_d = kd_pkg::LOAD;
            end
            default: state_d = kd_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= kd_pkg::IDLE;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            ready_q <= (state_d == kd_pkg::READY); // follows state, no extra lag
        end
    end

    assign cnt_clr_o      = load_start_i;
    assign cnt_adv_o      = load_wr;
    assign tbl_wen_o      = load_wr || host_wr; // never both at once
    assign tbl_sel_host_o = host_wr;
    assign ready_o        = ready_q;

endmodule

`default_nettype wire

//--- logic/kd_node_counter.sv
/*
 serial load address counter
 clears on request, steps per accepted word, flags the last node
*/

`timescale 1ns/1ps
`default_nettype none

`include "kd_params.svh"

module kd_node_counter (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  cnt_clr_i,  // restart at node 0
    input  wire                  cnt_adv_i,  // one word written
    output logic [`KD_DEPTH-1:0] cnt_addr_o,
    output logic                 cnt_last_o  // pointing at the final node
);

    logic [`KD_DEPTH-1:0] addr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (cnt_clr_i) begin // clear wins over advance
            addr_q <= '0;
        end else if (cnt_adv_i) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    assign cnt_addr_o = addr_q;
    assign cnt_last_o = (addr_q == `KD_DEPTH'(`KD_NODES - 1)); // node 62

endmodule

`default_nettype wire

//--- logic/kd_node_table.sv
/*
 node configuration table
 63 node registers with one write port, a registered host read and a flat search view
*/

`timescale 1ns/1ps
`default_nettype none

`include "kd_params.svh"

module kd_node_table (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire                                      wen_i,
    input  wire        [`KD_DEPTH-1:0]               waddr_i,
    input  wire        kd_pkg::node_cfg_t            wdata_i,
    input  wire                                      rd_i,
    input  wire        [`KD_DEPTH-1:0]               raddr_i,
    output kd_pkg::node_cfg_t                        rdata_o,
    output logic                                     rdata_valid_o,
    output kd_pkg::node_cfg_t [`KD_NODES-1:0]        nodes_o
);

    kd_pkg::node_cfg_t [`KD_NODES-1:0] node_q;
    kd_pkg::node_cfg_t                 rdata_q;
    logic                              rvalid_q;
    logic                              waddr_ok;
    logic                              raddr_ok;

    // 6-bit address reaches 63, which has no node
    assign waddr_ok = (waddr_i < `KD_DEPTH'(`KD_NODES));
    assign raddr_ok = (raddr_i < `KD_DEPTH'(`KD_NODES));

    // node storage, cleared so an unloaded tree sends everything right
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            node_q <= '0;
        end else if (wen_i && waddr_ok) begin
            node_q[waddr_i] <= wdata_i;
        end
    end

    // host read data, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rd_i) begin
            rdata_q <= raddr_ok ? node_q[raddr_i] : '0; // addr 63 reads as zero
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_i; // single-cycle pulse per read
        end
    end

    assign rdata_o       = rdata_q;
    assign rdata_valid_o = rvalid_q;
    assign nodes_o       = node_q; // both lanes look at the live table

endmodule

`default_nettype wire

//--- logic/kd_pkg.sv
/*
 kd-tree types
 patch, node config, lane stage and load state
*/

`default_nettype none

`include "kd_params.svh"

package kd_pkg;

    // one search patch, comp[0] in the low bits
    typedef struct packed {
        logic [`KD_COMPONENTS-1:0][`KD_COMP_WIDTH-1:0] comp;
    } patch_t;

    // 22-bit node word
    typedef struct packed {
        logic [`KD_COMP_WIDTH-1:0] comp_idx; // low 3 bits pick component, 5..7 map to 0
        logic [`KD_COMP_WIDTH-1:0] median;
    } node_cfg_t;

    // what moves from one tree level to the next
    typedef struct packed {
        logic                 valid;
        logic [`KD_DEPTH-1:0] pos;   // node position inside the level
        patch_t               patch;
    } lane_stage_t;

    // tree load controller states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LOAD  = 2'd1, // serial words being written
        READY = 2'd2  // tree complete, searches allowed
    } load_state_e;

endpackage

`default_nettype wire

//--- logic/kd_search_lane.sv
/*
 search lane
 KD_DEPTH chained levels turning a patch strobe into a leaf index
*/

`timescale 1ns/1ps
`default_nettype none

`include "kd_params.svh"

module kd_search_lane (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire                                     patch_valid_i, // ready gate applied above
    input  wire  kd_pkg::patch_t                    patch_i,
    input  wire  kd_pkg::node_cfg_t [`KD_NODES-1:0] nodes_i,
    output logic                                    leaf_valid_o,
    output logic [`KD_DEPTH-1:0]                    leaf_index_o
);

    // stage[k] enters level k, stage[KD_DEPTH] is the leaf
    kd_pkg::lane_stage_t stage [0:`KD_DEPTH];

    // every search starts at the root
    assign stage[0] = '{valid: patch_valid_i, pos: '0, patch: patch_i};

    genvar g;
    generate
        for (g = 0; g < `KD_DEPTH; g++) begin : g_level
            kd_search_level #(
                .LEVEL(g)
            ) u_level (
                .clk     (clk),
                .rst_n   (rst_n),
                .stage_i (stage[g]),
                .nodes_i (nodes_i),
                .stage_o (stage[g+1])
            );
        end
    endgenerate

    assign leaf_valid_o = stage[`KD_DEPTH].valid;
    assign leaf_index_o = stage[`KD_DEPTH].pos; // final position is the leaf

endmodule

`default_nettype wire

//--- logic/kd_search_level.sv
/*
 one registered search level
 picks this level's node, compares one component, steps left or right
*/

`timescale 1ns/1ps
`default_nettype none

`include "kd_params.svh"

module kd_search_level #(
    parameter int LEVEL = 0 // 0 is the root
) (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire  kd_pkg::lane_stage_t          stage_i,
    input  wire  kd_pkg::node_cfg_t [`KD_NODES-1:0] nodes_i,
    output kd_pkg::lane_stage_t                stage_o
);

    localparam int BASE = (1 << LEVEL) - 1; // first node index of this level

    logic [`KD_DEPTH-1:0]      node_idx;
    kd_pkg::node_cfg_t         node;
    logic [2:0]                comp_sel;
    logic [`KD_COMP_WIDTH-1:0] comp;
    logic                      go_right;
    logic                      valid_q;
    logic [`KD_DEPTH-1:0]      pos_q;
    kd_pkg::patch_t            patch_q;

    assign node_idx = `KD_DEPTH'(BASE) + stage_i.pos; // pos < 2^LEVEL, stays below 63
    assign node     = nodes_i[node_idx];

    // out-of-range selects fall back to component 0
    assign comp_sel = (node.comp_idx[2:0] < 3'(`KD_COMPONENTS)) ? node.comp_idx[2:0] : 3'd0;
    assign comp     = stage_i.patch.comp[comp_sel];
    assign go_right = (comp >= node.median); // ties go right

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_i.valid;
        end
    end

    // payload moves every cycle, valid qualifies it
    always_ff @(posedge clk) begin
        pos_q   <= {stage_i.pos[`KD_DEPTH-2:0], go_right}; // 2*pos + right
        patch_q <= stage_i.patch;
    end

    assign stage_o = '{valid: valid_q, pos: pos_q, patch: patch_q};

endmodule

`default_nettype wire

//--- logic/kd_tree_top.sv
/*
 kd-tree leaf search top
 load controller, node table and two independent search lanes
*/

`timescale 1ns/1ps
`default_nettype none

`include "kd_params.svh"

module kd_tree_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         load_start_i,
    input  wire                         load_valid_i,
    input  wire  kd_pkg::node_cfg_t     load_data_i,
    input  wire                         cfg_wr_i,
    input  wire                         cfg_rd_i,
    input  wire  [`KD_DEPTH-1:0]        cfg_addr_i,
    input  wire  kd_pkg::node_cfg_t     cfg_wdata_i,
    output kd_pkg::node_cfg_t           cfg_rdata_o,
    output logic                        cfg_rdata_valid_o,
    output logic                        ready_o,
    input  wire                         patch_a_valid_i,
    input  wire                         patch_b_valid_i,
    input  wire  kd_pkg::patch_t        patch_a_i,
    input  wire  kd_pkg::patch_t        patch_b_i,
    output logic                        leaf_a_valid_o,
    output logic                        leaf_b_valid_o,
    output logic [`KD_DEPTH-1:0]        leaf_a_index_o,
    output logic [`KD_DEPTH-1:0]        leaf_b_index_o
);

    logic                              cnt_clr;
    logic                              cnt_adv;
    logic [`KD_DEPTH-1:0]              cnt_addr;
    logic                              cnt_last;
    logic                              tbl_wen;
    logic                              tbl_sel_host;
    logic [`KD_DEPTH-1:0]              tbl_waddr;
    kd_pkg::node_cfg_t                 tbl_wdata;
    kd_pkg::node_cfg_t [`KD_NODES-1:0] nodes;

    // write port source, host or serial stream
    assign tbl_waddr = tbl_sel_host ? cfg_addr_i : cnt_addr;
    assign tbl_wdata = tbl_sel_host ? cfg_wdata_i : load_data_i;

    kd_load_fsm u_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .load_start_i   (load_start_i),
        .load_valid_i   (load_valid_i),
        .cfg_wr_i       (cfg_wr_i),
        .cnt_last_i     (cnt_last),
        .cnt_clr_o      (cnt_clr),
        .cnt_adv_o      (cnt_adv),
        .tbl_wen_o      (tbl_wen),
        .tbl_sel_host_o (tbl_sel_host),
        .ready_o        (ready_o)
    );

    kd_node_counter u_cnt (
        .clk        (clk),
        .rst_n      (rst_n),
        .cnt_clr_i  (cnt_clr),
        .cnt_adv_i  (cnt_adv),
        .cnt_addr_o (cnt_addr),
        .cnt_last_o (cnt_last)
    );

    kd_node_table u_tbl (
        .clk           (clk),
        .rst_n         (rst_n),
        .wen_i         (tbl_wen),
        .waddr_i       (tbl_waddr),
        .wdata_i       (tbl_wdata),
        .rd_i          (cfg_rd_i),
        .raddr_i       (cfg_addr_i), // reads allowed in any state
        .rdata_o       (cfg_rdata_o),
        .rdata_valid_o (cfg_rdata_valid_o),
        .nodes_o       (nodes)
    );

    // patches only enter while the tree is complete
    kd_search_lane u_lane_a (
        .clk           (clk),
        .rst_n         (rst_n),
        .patch_valid_i (patch_a_valid_i && ready_o),
        .patch_i       (patch_a_i),
        .nodes_i       (nodes),
        .leaf_valid_o  (leaf_a_valid_o),
        .leaf_index_o  (leaf_a_index_o)
    );

    kd_search_lane u_lane_b (
        .clk           (clk),
        .rst_n         (rst_n),
        .patch_valid_i (patch_b_valid_i && ready_o),
        .patch_i       (patch_b_i),
        .nodes_i       (nodes),
        .leaf_valid_o  (leaf_b_valid_o),
        .leaf_index_o  (leaf_b_index_o)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build the kd-tree testbench with Verilator, run it, pass only on the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f sources.f --top-module tb_kd_tree \
    -Mdir obj_dir -o tb_kd_tree &&
    ./obj_dir/tb_kd_tree | tee /dev/stderr | grep "TEST PASSED" > /dev/null &&
    echo "simulation passed" ||
    { echo "simulation did not pass"; exit 1; }

//--- sources.f
+incdir+.
+incdir+testbench
logic/kd_pkg.sv
logic/kd_node_counter.sv
logic/kd_load_fsm.sv
logic/kd_node_table.sv
logic/kd_search_level.sv
logic/kd_search_lane.sv
logic/kd_tree_top.sv
testbench/tb_kd_tree.sv

//--- testbench/tb_kd_ref.svh
/*
 kd-tree reference model
 node mirror, leaf walk, expected-result queues and a random tree builder
*/

`ifndef TB_KD_REF_SVH
`define TB_KD_REF_SVH

kd_pkg::node_cfg_t    mirror [0:`KD_NODES];   // entry 63 stays zero like the unmapped address
kd_pkg::node_cfg_t    tree [0:`KD_NODES-1];   // image for the next serial load
kd_pkg::load_state_e  m_state;
int                   m_ptr;                  // next serial write address
logic [`KD_DEPTH-1:0] exp_a_leaf [$];
logic [`KD_DEPTH-1:0] exp_b_leaf [$];
kd_pkg::node_cfg_t    exp_rdata [$];

function automatic void model_reset();
    for (int n = 0; n <= `KD_NODES; n++) begin
        mirror[n] = '0;
    end
    m_state = kd_pkg::IDLE;
    m_ptr   = 0;
    exp_a_leaf.delete();
    exp_b_leaf.delete();
    exp_rdata.delete();
endfunction

// writes committed at this edge, host first since it sees the old state
function automatic void model_step();
    if (cfg_wr_i && m_state != kd_pkg::LOAD && cfg_addr_i < `KD_NODES) begin
        mirror[cfg_addr_i] = cfg_wdata_i;
    end
    if (load_start_i) begin
        m_state = kd_pkg::LOAD;
        m_ptr   = 0;
    end else if (m_state == kd_pkg::LOAD && load_valid_i) begin
        mirror[m_ptr] = load_data_i;
        if (m_ptr == `KD_NODES - 1) m_state = kd_pkg::READY; // last node done
        m_ptr++;
    end
endfunction

// root to leaf, right when component >= median
function automatic logic [`KD_DEPTH-1:0] walk_leaf(input kd_pkg::patch_t p);
    int unsigned       pos;
    int unsigned       sel;
    int                k;
    kd_pkg::node_cfg_t nd;
    pos = 0;
    for (k = 0; k < `KD_DEPTH; k++) begin
        nd  = mirror[(1 << k) - 1 + pos];
        sel = nd.comp_idx[2:0];
        if (sel >= `KD_COMPONENTS) sel = 0; // 5..7 fall back to comp 0
        pos = 2 * pos + ((p.comp[sel] >= nd.median) ? 1 : 0);
    end
    return pos[`KD_DEPTH-1:0];
endfunction

function automatic kd_pkg::patch_t rand_patch();
    kd_pkg::patch_t p;
    for (int k = 0; k < `KD_COMPONENTS; k++) begin
        p.comp[k] = `KD_COMP_WIDTH'($urandom);
    end
    return p;
endfunction

function automatic void build_tree();
    for (int n = 0; n < `KD_NODES; n++) begin
        tree[n].comp_idx = `KD_COMP_WIDTH'($urandom); // upper bits junk on purpose
        tree[n].median   = `KD_COMP_WIDTH'($urandom);
    end
endfunction

`endif

//--- testbench/tb_kd_tree.sv
/*
 kd-tree leaf search testbench
 random trees, both lanes and the host port checked against a reference model
*/

`timescale 1ns/1ps
`default_nettype none

`include "kd_params.svh"

module tb_kd_tree;

    logic                 clk;
    logic                 rst_n;
    logic                 load_start_i;
    logic                 load_valid_i;
    kd_pkg::node_cfg_t    load_data_i;
    logic                 cfg_wr_i;
    logic                 cfg_rd_i;
    logic [`KD_DEPTH-1:0] cfg_addr_i;
    kd_pkg::node_cfg_t    cfg_wdata_i;
    kd_pkg::node_cfg_t    cfg_rdata_o;
    logic                 cfg_rdata_valid_o;
    logic                 ready_o;
    logic                 patch_a_valid_i;
    logic                 patch_b_valid_i;
    kd_pkg::patch_t       patch_a_i;
    kd_pkg::patch_t       patch_b_i;
    logic                 leaf_a_valid_o;
    logic                 leaf_b_valid_o;
    logic [`KD_DEPTH-1:0] leaf_a_index_o;
    logic [`KD_DEPTH-1:0] leaf_b_index_o;

    logic                 rd_q;      // read strobe from the previous edge
    logic [`KD_DEPTH-1:0] exp_leaf;
    kd_pkg::node_cfg_t    exp_node;
    kd_pkg::patch_t       sp;        // hand-built patch
    int                   idx;
    int                   err_cnt;
    int                   test_cnt;
    int                   err_base;  // err_cnt when the current test began

    `include "tb_kd_ref.svh"

    kd_tree_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns
    end

    function automatic void report_mismatch(input string sig, input int unsigned exp_v,
                                             input int unsigned act_v);
        $display("CHECK FAILED t=%0t %s expected 0x%0h got 0x%0h", $time, sig, exp_v, act_v);
        err_cnt++;
    endfunction

    function automatic void report_error(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        err_cnt++;
    endfunction

    // pre-edge outputs checked before the model moves
    always @(posedge clk) begin
        if (!rst_n) begin
            model_reset();
            rd_q = 1'b0;
        end else begin
            assert (ready_o == (m_state == kd_pkg::READY))
                else report_mismatch("ready_o", m_state == kd_pkg::READY, ready_o);
            assert (cfg_rdata_valid_o == rd_q)
                else report_mismatch("cfg_rdata_valid_o", rd_q, cfg_rdata_valid_o);
            if (rd_q) begin
                exp_node = exp_rdata.pop_front();
                assert (cfg_rdata_o == exp_node)
                    else report_mismatch("cfg_rdata_o", exp_node, cfg_rdata_o);
            end
            assert (!(leaf_a_valid_o && exp_a_leaf.size() == 0))
                else report_error("lane A gave a leaf with no search in flight");
            if (leaf_a_valid_o && exp_a_leaf.size() != 0) begin
                exp_leaf = exp_a_leaf.pop_front();
                assert (leaf_a_index_o == exp_leaf)
                    else report_mismatch("leaf_a_index_o", exp_leaf, leaf_a_index_o);
            end
            assert (!(leaf_b_valid_o && exp_b_leaf.size() == 0))
                else report_error("lane B gave a leaf with no search in flight");
            if (leaf_b_valid_o && exp_b_leaf.size() != 0) begin
                exp_leaf = exp_b_leaf.pop_front();
                assert (leaf_b_index_o == exp_leaf)
                    else report_mismatch("leaf_b_index_o", exp_leaf, leaf_b_index_o);
            end
            rd_q = cfg_rd_i;
            if (cfg_rd_i) exp_rdata.push_back(mirror[cfg_addr_i]);
            if (m_state == kd_pkg::READY && patch_a_valid_i) begin
                exp_a_leaf.push_back(walk_leaf(patch_a_i));
            end
            if (m_state == kd_pkg::READY && patch_b_valid_i) begin
                exp_b_leaf.push_back(walk_leaf(patch_b_i));
            end
            model_step();
        end
    end

    task automatic abort_run(input string msg);
        err_cnt++;
        $display("timeout: %s", msg);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        $display("test %0d %s: %s", test_cnt, name, (err_cnt == err_base) ? "ok" : "errors");
        err_base = err_cnt;
    endtask

    task automatic wait_ready(input logic want);
        int n;
        n = 0;
        while (ready_o !== want && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (ready_o !== want) abort_run("ready_o never reached the expected level");
    endtask

    // until every expected leaf and read has been matched
    task automatic drain_results();
        int n;
        n = 0;
        while (exp_a_leaf.size() + exp_b_leaf.size() + exp_rdata.size() != 0 && n < 30) begin
            @(negedge clk);
            n++;
        end
        if (exp_a_leaf.size() + exp_b_leaf.size() + exp_rdata.size() != 0) begin
            abort_run("search or read results never arrived");
        end
    endtask

    task automatic drive_random_patches();
        patch_a_valid_i = ($urandom_range(3) != 0); // about one idle in four
        patch_b_valid_i = ($urandom_range(3) != 0);
        patch_a_i       = rand_patch();
        patch_b_i       = rand_patch();
    endtask

    task automatic host_write(input logic [`KD_DEPTH-1:0] addr, input kd_pkg::node_cfg_t data);
        cfg_wr_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(negedge clk);
        cfg_wr_i = 1'b0;
    endtask

    task automatic load_tree(input bit with_patches);
        int n;
        int gap;
        build_tree();
        load_start_i = 1'b1;
        @(negedge clk);
        load_start_i = 1'b0;
        assert (ready_o == 1'b0) else report_mismatch("ready_o", 0, ready_o);
        for (n = 0; n < `KD_NODES; n++) begin
            gap = $urandom_range(2);
            repeat (gap) begin
                load_valid_i = 1'b0;
                if (with_patches) drive_random_patches();
                @(negedge clk);
            end
            load_valid_i = 1'b1;
            load_data_i  = tree[n];
            if (with_patches) drive_random_patches();
            @(negedge clk);
        end
        load_valid_i    = 1'b0;
        patch_a_valid_i = 1'b0;
        patch_b_valid_i = 1'b0;
    endtask

    // lane A patch with latency counted from the sampling edge
    task automatic single_search_a(input kd_pkg::patch_t p);
        int n;
        patch_a_i       = p;
        patch_a_valid_i = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            patch_a_valid_i = 1'b0;
            n++;
        end while (!leaf_a_valid_o && n < 20);
        if (!leaf_a_valid_o) abort_run("lane A leaf never arrived");
        assert (n == `KD_DEPTH) else report_mismatch("leaf_a_valid_o latency", `KD_DEPTH, n);
    endtask

    initial begin
        void'($urandom(85));
        err_cnt  = 0;
        test_cnt = 0;
        err_base = 0;
        rst_n           = 1'b0;
        load_start_i    = 1'b0;
        load_valid_i    = 1'b0;
        load_data_i     = '0;
        cfg_wr_i        = 1'b0;
        cfg_rd_i        = 1'b0;
        cfg_addr_i      = '0;
        cfg_wdata_i     = '0;
        patch_a_valid_i = 1'b0;
        patch_b_valid_i = 1'b0;
        patch_a_i       = '0;
        patch_b_i       = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // no tree yet so patches must vanish
        assert (ready_o == 1'b0) else report_mismatch("ready_o", 0, ready_o);
        drive_random_patches();
        patch_a_valid_i = 1'b1;
        patch_b_valid_i = 1'b1;
        @(negedge clk);
        patch_a_valid_i = 1'b0;
        patch_b_valid_i = 1'b0;
        repeat (10) begin
            @(negedge clk);
            assert (!leaf_a_valid_o && !leaf_b_valid_o)
                else report_error("leaf valid before any tree was loaded");
        end
        end_test("idle after reset");

        load_tree(1'b0);
        wait_ready(1'b1);
        for (idx = 0; idx < `KD_NODES; idx++) begin
            cfg_rd_i   = 1'b1;
            cfg_addr_i = idx[`KD_DEPTH-1:0];
            @(negedge clk);
        end
        cfg_rd_i = 1'b0;
        drain_results();
        end_test("serial load and readback");

        host_write(6'd0, '{comp_idx: 11'h406, median: 11'h300}); // low bits 6 select comp 0
        sp         = rand_patch();
        sp.comp[0] = 11'h300; // tie
        single_search_a(sp);
        assert (leaf_a_index_o[`KD_DEPTH-1]) else report_mismatch("leaf_a_index_o msb", 1, 0);
        host_write(6'd0, '{comp_idx: 11'h005, median: 11'h300});
        sp.comp[0] = 11'h2ff; // one below the median
        single_search_a(sp);
        assert (!leaf_a_index_o[`KD_DEPTH-1]) else report_mismatch("leaf_a_index_o msb", 0, 1);
        drain_results();
        end_test("single search and tie");

        repeat (200) begin
            drive_random_patches();
            @(negedge clk);
        end
        patch_a_valid_i = 1'b0;
        patch_b_valid_i = 1'b0;
        drain_results();
        end_test("random traffic on both lanes");

        host_write(6'd0, '{comp_idx: 11'd2, median: 11'd0}); // root now always right
        repeat (20) begin
            drive_random_patches();
            @(negedge clk);
        end
        patch_a_valid_i = 1'b0;
        patch_b_valid_i = 1'b0;
        drain_results();
        load_tree(1'b1); // patches offered all through the reload
        wait_ready(1'b1);
        drain_results();
        end_test("host write and reload");

        $display("summary: %0d tests, %0d errors", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
